// ==== sim.f ====
+incdir+.
csr_pkg.sv
eng_pkg.sv
engine_csr_if.sv
csr_mgr.sv
mem_copy_engine.sv
afu_top.sv
afu_checker.sv
tb_afu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_afu -f sim.f -o tb_afu &&
    ./obj_dir/tb_afu > sim.log 2>&1
grep -qxF "Done: no errors" sim.log && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}

// ==== tb_afu.sv ====
// ======================================
// Directed testbench with memory model,
// clock, reset, watchdog and checks
// ======================================

`timescale 1ns/100ps
`default_nettype none

`include "afu_macros.svh"

module tb_afu;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 5;
    localparam int POLL_LIMIT = 500;
    localparam logic [127:0] TEST_ID = `AFU_TEST_ID;

    // Engine block starts at word address 8
    localparam logic [5:0] A_CTRL   = 6'd8;
    localparam logic [5:0] A_SRC    = 6'd9;
    localparam logic [5:0] A_DST    = 6'd10;
    localparam logic [5:0] A_LEN    = 6'd11;
    localparam logic [5:0] A_STATUS = 6'd12;
    localparam logic [5:0] A_COUNT  = 6'd13;
    localparam logic [5:0] A_SUM    = 6'd14;

    logic        clk;
    logic        rst_n;
    logic        mmio_write;
    logic        mmio_read;
    logic [5:0]  mmio_address;
    logic [63:0] mmio_writedata;
    logic        mmio_readdatavalid;
    logic [63:0] mmio_readdata;
    logic        mem_req;
    logic        mem_we;
    logic [63:0] mem_addr;
    logic [63:0] mem_wdata;
    logic        mem_ack;
    logic [63:0] mem_rdata;

    // Host memory, one word per line
    logic [63:0] mem [256];
    // Source words of the latest fill
    logic [63:0] ref_words [16];

    int check_count  = 0;
    int error_count  = 0;
    int access_count = 0;

    afu_top u_afu_top
    (
        .clk                (clk),
        .rst_n              (rst_n),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_address       (mmio_address),
        .mmio_writedata     (mmio_writedata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .mmio_readdata      (mmio_readdata),
        .mem_req            (mem_req),
        .mem_we             (mem_we),
        .mem_addr           (mem_addr),
        .mem_wdata          (mem_wdata),
        .mem_ack            (mem_ack),
        .mem_rdata          (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ======================================
    // Memory model, four-phase responder
    // ======================================

    initial
    begin : mem_model
        int delay;
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
        forever
        begin
            @(posedge clk);
            if (mem_req && !mem_ack)
            begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge clk);
                // Request can vanish under reset
                if (mem_req)
                begin
                    if (mem_we)
                    begin
                        mem[mem_addr[7:0]] <= mem_wdata;
                    end
                    else
                    begin
                        mem_rdata <= mem[mem_addr[7:0]];
                    end
                    mem_ack <= 1'b1;
                    access_count++;
                    @(posedge clk);
                    while (mem_req)
                    begin
                        @(posedge clk);
                    end
                    delay = $urandom_range(3, 0);
                    repeat (delay) @(posedge clk);
                    mem_ack <= 1'b0;
                end
            end
        end
    end

    // Watchdog sized from the test count
    initial
    begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("Timeout: tests still running after %0d cycles", NUM_TESTS * 2000);
        $display("Done: errors found");
        $finish;
    end

    // ======================================
    // Host access and check tasks
    // ======================================

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic mmio_wr(input logic [5:0] addr, input logic [63:0] data);
        @(posedge clk);
        mmio_write     <= 1'b1;
        mmio_address   <= addr;
        mmio_writedata <= data;
        @(posedge clk);
        mmio_write <= 1'b0;
    endtask

    // Valid and data sampled on the falling edge one cycle after the strobe
    task automatic mmio_rd(input logic [5:0] addr, output logic [63:0] data);
        @(posedge clk);
        mmio_read    <= 1'b1;
        mmio_address <= addr;
        @(posedge clk);
        mmio_read <= 1'b0;
        @(negedge clk);
        if (!mmio_readdatavalid)
        begin
            error_count++;
            $display("Read of address %0d gave no readdatavalid one cycle later", addr);
        end
        data = mmio_readdata;
    endtask

    task automatic fill_source(input int base, input int n, output logic [63:0] sum);
        logic [63:0] word;
        sum = '0;
        for (int i = 0; i < n; i++)
        begin
            word         = {$urandom, $urandom};
            ref_words[i] = word;
            mem[base + i] <= word;
            sum          = sum + word;
        end
    endtask

    task automatic start_copy(input logic [63:0] src, input logic [63:0] dst,
                              input logic [63:0] len);
        mmio_wr(A_SRC, src);
        mmio_wr(A_DST, dst);
        mmio_wr(A_LEN, len);
        mmio_wr(A_CTRL, 64'h1);
    endtask

    // Poll STATUS until the done bit
    task automatic wait_done(output logic [63:0] status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < POLL_LIMIT)
        begin
            mmio_rd(A_STATUS, status);
            polls++;
        end
        if (!status[1])
        begin
            error_count++;
            $display("Copy did not set done within %0d status reads", POLL_LIMIT);
        end
    endtask

    task automatic check_totals(input logic [63:0] exp_count, input logic [63:0] exp_sum);
        logic [63:0] rd;
        mmio_rd(A_COUNT, rd);
        check_val("COUNT", exp_count, rd);
        mmio_rd(A_SUM, rd);
        check_val("SUM", exp_sum, rd);
    endtask

    task automatic check_dest(input int base, input int n);
        for (int i = 0; i < n; i++)
        begin
            check_val("mem dst line", ref_words[i], mem[base + i]);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (error_count == err0)
        begin
            $display("Test %s: passed", name);
        end
        else
        begin
            $display("Test %s: failed with %0d errors", name, error_count - err0);
        end
    endtask

    // ======================================
    // Tests
    // ======================================

    task automatic test_id_regs();
        logic [63:0] rd;
        logic [63:0] info_exp;
        int          err0;
        err0     = error_count;
        // Engines in the low byte, instance in bits 31 to 24
        info_exp = {32'd0, 8'(`AFU_INSTANCE_ID), 16'd0, 8'(`AFU_NUM_ENGINES)};
        mmio_rd(6'd0, rd);
        check_val("ID_LO", TEST_ID[63:0], rd);
        mmio_rd(6'd1, rd);
        check_val("ID_HI", TEST_ID[127:64], rd);
        mmio_rd(6'd2, rd);
        check_val("INFO", info_exp, rd);
        mmio_rd(6'd20, rd);
        check_val("unmapped word 20", 64'd0, rd);
        mmio_rd(6'd63, rd);
        check_val("unmapped word 63", 64'd0, rd);
        report_test("identity registers", err0);
    endtask

    task automatic test_copy_16();
        logic [63:0] sum;
        logic [63:0] status;
        int          err0;
        err0 = error_count;
        fill_source(16, 16, sum);
        start_copy(64'd16, 64'd64, 64'd16);
        wait_done(status);
        check_val("STATUS", 64'h2, status);
        check_totals(64'd16, sum);
        check_dest(64, 16);
        report_test("copy of 16 lines", err0);
    endtask

    task automatic test_copy_empty();
        logic [63:0] snap [256];
        logic [63:0] status;
        int          changed;
        int          acc0;
        int          err0;
        err0 = error_count;
        for (int i = 0; i < 256; i++)
        begin
            snap[i] = mem[i];
        end
        acc0 = access_count;
        start_copy(64'd16, 64'd200, 64'd0);
        wait_done(status);
        check_val("STATUS", 64'h2, status);
        check_totals(64'd0, 64'd0);
        check_val("memory accesses", 64'd0, 64'(access_count - acc0));
        changed = 0;
        for (int i = 0; i < 256; i++)
        begin
            if (mem[i] !== snap[i])
            begin
                changed++;
            end
        end
        check_val("changed memory lines", 64'd0, 64'(changed));
        report_test("copy of zero lines", err0);
    endtask

    task automatic test_busy_start();
        logic [63:0] sum;
        logic [63:0] status;
        int          acc0;
        int          err0;
        err0 = error_count;
        fill_source(96, 8, sum);
        acc0 = access_count;
        start_copy(64'd96, 64'd128, 64'd8);
        // Second start lands while the engine is busy
        mmio_wr(A_CTRL, 64'h1);
        wait_done(status);
        check_val("STATUS", 64'h2, status);
        check_totals(64'd8, sum);
        check_dest(128, 8);
        // One read and one write per line, no restart
        check_val("memory accesses", 64'd16, 64'(access_count - acc0));
        report_test("start while busy", err0);
    endtask

    task automatic test_src_and_reset();
        logic [63:0] value;
        logic [63:0] rd;
        int          acc0;
        int          waited;
        int          err0;
        err0  = error_count;
        value = {$urandom, $urandom};
        mmio_wr(A_SRC, value);
        mmio_rd(A_SRC, rd);
        check_val("SRC", value, rd);
        fill_source(16, 16, rd);
        acc0 = access_count;
        start_copy(64'd16, 64'd160, 64'd16);
        // Let a few handshakes pass first
        waited = 0;
        while ((access_count - acc0) < 5 && waited < POLL_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if ((access_count - acc0) < 5)
        begin
            error_count++;
            $display("Copy made fewer than 5 memory accesses before the reset");
        end
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_val("mem_req", 64'd0, {63'd0, mem_req});
        @(posedge clk);
        rst_n <= 1'b1;
        mmio_rd(A_STATUS, rd);
        check_val("STATUS", 64'd0, rd);
        check_totals(64'd0, 64'd0);
        mmio_rd(A_SRC, rd);
        check_val("SRC", 64'd0, rd);
        report_test("SRC readback and reset mid-copy", err0);
    endtask

    // ======================================
    // Main sequence
    // ======================================

    initial
    begin
        void'($urandom(32'h16c0));
        rst_n          <= 1'b0;
        mmio_write     <= 1'b0;
        mmio_read      <= 1'b0;
        mmio_address   <= '0;
        mmio_writedata <= '0;
        // Fill pattern built from all eight address bits
        for (int i = 0; i < 256; i++)
        begin
            mem[i] <= {24'h5a5a5a, i[7:0], 24'hc3c3c3, ~i[7:0]};
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_id_regs();
        test_copy_16();
        test_copy_empty();
        test_busy_start();
        test_src_and_reset();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== afu_checker.sv ====
// ======================================
// Memory handshake and register read
// assertions, bound into the top level
// ======================================

`timescale 1ns/100ps
`default_nettype none

module afu_checker
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mmio_read,
    input  logic        mmio_readdatavalid,
    input  logic        mem_req,
    input  logic        mem_we,
    input  logic [63:0] mem_addr,
    input  logic [63:0] mem_wdata,
    input  logic        mem_ack
);

    // ======================================
    // Four-phase memory side
    // ======================================

    // Request held until the memory answers
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack");

    // Request fields frozen while the request stays up
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_we)
            && $stable(mem_wdata))
        else $error("mem_addr, mem_we or mem_wdata changed during a request");

    // New request only after the previous ack is gone
    req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !mem_ack)
        else $error("mem_req rose while mem_ack was high");

    // Reset clears the requester
    req_reset: assert property (@(posedge clk)
        !rst_n |=> !mem_req)
        else $error("mem_req high after reset");

    // ======================================
    // Register read latency
    // ======================================

    rd_valid: assert property (@(posedge clk) disable iff (!rst_n)
        mmio_read |=> mmio_readdatavalid)
        else $error("mmio_readdatavalid missing one cycle after mmio_read");

    rd_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !mmio_read |=> !mmio_readdatavalid)
        else $error("mmio_readdatavalid without a read one cycle earlier");

endmodule

bind afu_top afu_checker u_afu_checker
(
    .clk                (clk),
    .rst_n              (rst_n),
    .mmio_read          (mmio_read),
    .mmio_readdatavalid (mmio_readdatavalid),
    .mem_req            (mem_req),
    .mem_we             (mem_we),
    .mem_addr           (mem_addr),
    .mem_wdata          (mem_wdata),
    .mem_ack            (mem_ack)
);

`default_nettype wire

// ==== afu_top.sv ====
// ======================================
// Accelerator top with global registers,
// register manager and copy engine
// ======================================

`timescale 1ns/100ps
`default_nettype none

`include "afu_macros.svh"

module afu_top
    import csr_pkg::*, eng_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,

    // Host register port
    input  logic                        mmio_write,
    input  logic                        mmio_read,
    input  logic [`AFU_MMIO_ADDR_W-1:0] mmio_address,
    input  logic [`AFU_DATA_W-1:0]      mmio_writedata,
    output logic                        mmio_readdatavalid,
    output logic [`AFU_DATA_W-1:0]      mmio_readdata,

    // Host memory port
    output logic                        mem_req,
    output logic                        mem_we,
    output mem_addr_t                   mem_addr,
    output logic [`AFU_DATA_W-1:0]      mem_wdata,
    input  logic                        mem_ack,
    input  logic [`AFU_DATA_W-1:0]      mem_rdata
);

    localparam logic [127:0] TEST_ID = `AFU_TEST_ID;

    engine_csr_if eng_csr_glob();
    engine_csr_if eng_csr_eng();

    // ======================================
    // Global block, read-only identity
    // ======================================

    always_comb
    begin
        for (int i = 0; i < `AFU_NUM_CSRS; i++)
        begin
            eng_csr_glob.rd_data[i] = '0;
        end
        eng_csr_glob.rd_data[CSR_GLOB_ID_LO] = TEST_ID[63:0];
        eng_csr_glob.rd_data[CSR_GLOB_ID_HI] = TEST_ID[127:64];
        eng_csr_glob.rd_data[CSR_GLOB_INFO]  =
            csr_info_word(8'(`AFU_INSTANCE_ID), 8'(`AFU_NUM_ENGINES));
        // No work ever runs in this block
        eng_csr_glob.status_active = 1'b0;
    end

    // ======================================
    // Register manager and engine
    // ======================================

    csr_mgr u_csr_mgr
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_write      (mmio_write),
        .rd_read       (mmio_read),
        .address       (mmio_address),
        .writedata     (mmio_writedata),
        .readdatavalid (mmio_readdatavalid),
        .readdata      (mmio_readdata),
        .eng_csr_glob  (eng_csr_glob),
        .eng_csr       (eng_csr_eng)
    );

    mem_copy_engine u_engine
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .csrs      (eng_csr_eng),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== mem_copy_engine.sv ====
// ======================================
// Host memory copy engine with its
// registers and four-phase requester
// ======================================

`timescale 1ns/100ps
`default_nettype none

`include "afu_macros.svh"

module mem_copy_engine
    import csr_pkg::*, eng_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Register block side
    engine_csr_if.block            csrs,

    // Four-phase memory requester
    output logic                   mem_req,
    output logic                   mem_we,
    output mem_addr_t              mem_addr,
    output logic [`AFU_DATA_W-1:0] mem_wdata,
    input  logic                   mem_ack,
    input  logic [`AFU_DATA_W-1:0] mem_rdata
);

    eng_state_t             state;
    mem_addr_t              src;
    mem_addr_t              dst;
    mem_addr_t              len;
    mem_addr_t              line_idx;
    mem_addr_t              line_next;
    logic [`AFU_DATA_W-1:0] count;
    logic [`AFU_DATA_W-1:0] sum;
    logic [`AFU_DATA_W-1:0] data_q;
    logic                   busy;
    logic                   done;
    logic                   start;
    logic                   wr_phase;

    // Done state still counts as idle for a new start
    assign busy = (state != ENG_IDLE) && (state != ENG_DONE);
    assign done = (state == ENG_DONE);

    // CTRL write with the start bit set
    assign start = csrs.wr_en && (csrs.wr_idx == CSR_ENG_CTRL)
                   && csrs.wr_data[CTRL_START_BIT] && !busy;

    assign line_next = line_idx + 1'b1;

    // ======================================
    // Host-written configuration
    // ======================================

    // Locked while a copy runs so request fields hold steady
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            src <= '0;
            dst <= '0;
            len <= '0;
        end
        else if (csrs.wr_en && !busy)
        begin
            case (csrs.wr_idx)
                CSR_ENG_SRC: src <= csrs.wr_data;
                CSR_ENG_DST: dst <= csrs.wr_data;
                CSR_ENG_LEN: len <= csrs.wr_data;
                default:     ;
            endcase
        end
    end

    // ======================================
    // Copy FSM
    // ======================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= ENG_IDLE;
            line_idx <= '0;
            count    <= '0;
            sum      <= '0;
        end
        else
        begin
            case (state)
                ENG_IDLE, ENG_DONE:
                begin
                    if (start)
                    begin
                        line_idx <= '0;
                        count    <= '0;
                        sum      <= '0;
                        // Empty copy goes straight to done
                        state    <= (len == '0) ? ENG_DONE : ENG_RD_REQ;
                    end
                end
                ENG_RD_REQ:
                begin
                    if (mem_ack)
                    begin
                        sum   <= sum + mem_rdata;
                        state <= ENG_RD_REL;
                    end
                end
                ENG_RD_REL:
                begin
                    if (!mem_ack)
                    begin
                        state <= ENG_WR_REQ;
                    end
                end
                ENG_WR_REQ:
                begin
                    if (mem_ack)
                    begin
                        count <= count + 1'b1;
                        state <= ENG_WR_REL;
                    end
                end
                ENG_WR_REL:
                begin
                    if (!mem_ack)
                    begin
                        line_idx <= line_next;
                        state    <= (line_next == len) ? ENG_DONE : ENG_RD_REQ;
                    end
                end
                default:
                begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // Line buffer between the read and the write
    always_ff @(posedge clk)
    begin
        if ((state == ENG_RD_REQ) && mem_ack)
        begin
            data_q <= mem_rdata;
        end
    end

    // ======================================
    // Memory outputs and register view
    // ======================================

    assign wr_phase  = (state == ENG_WR_REQ) || (state == ENG_WR_REL);
    assign mem_req   = (state == ENG_RD_REQ) || (state == ENG_WR_REQ);
    assign mem_we    = wr_phase;
    assign mem_addr  = wr_phase ? (dst + line_idx) : (src + line_idx);
    assign mem_wdata = data_q;

    always_comb
    begin
        for (int i = 0; i < `AFU_NUM_CSRS; i++)
        begin
            csrs.rd_data[i] = '0;
        end
        // CTRL start is a pulse and reads back zero
        csrs.rd_data[CSR_ENG_SRC]    = src;
        csrs.rd_data[CSR_ENG_DST]    = dst;
        csrs.rd_data[CSR_ENG_LEN]    = len;
        csrs.rd_data[CSR_ENG_STATUS][STATUS_BUSY_BIT] = busy;
        csrs.rd_data[CSR_ENG_STATUS][STATUS_DONE_BIT] = done;
        csrs.rd_data[CSR_ENG_COUNT]  = count;
        csrs.rd_data[CSR_ENG_SUM]    = sum;
    end

    assign csrs.status_active = busy;

endmodule

`default_nettype wire

// ==== csr_mgr.sv ====
// ======================================
// Host register decode into the global
// and engine blocks, one-cycle reads
// ======================================

`timescale 1ns/100ps
`default_nettype none

`include "afu_macros.svh"

module csr_mgr
    import csr_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    // Host register port
    input  logic                       wr_write,
    input  logic                       rd_read,
    input  logic [`AFU_MMIO_ADDR_W-1:0] address,
    input  logic [`AFU_DATA_W-1:0]     writedata,
    output logic                       readdatavalid,
    output logic [`AFU_DATA_W-1:0]     readdata,

    // Register blocks
    engine_csr_if.manager              eng_csr_glob,
    engine_csr_if.manager              eng_csr
);

    // ======================================
    // Address split
    // ======================================

    csr_blk_t               blk;
    csr_idx_t               idx;
    logic [`AFU_DATA_W-1:0] rd_word;

    // Upper bits pick the block, lower bits the register
    assign blk = address[`AFU_MMIO_ADDR_W-1:CSR_IDX_W];
    assign idx = address[CSR_IDX_W-1:0];

    // ======================================
    // Write forwarding
    // ======================================

    // Strobe lasts exactly as long as the host write
    assign eng_csr_glob.wr_en   = wr_write && (blk == CSR_BLK_GLOB);
    assign eng_csr_glob.wr_idx  = idx;
    assign eng_csr_glob.wr_data = writedata;

    // Register number checks happen inside the block
    assign eng_csr.wr_en   = wr_write && (blk == CSR_BLK_ENG);
    assign eng_csr.wr_idx  = idx;
    assign eng_csr.wr_data = writedata;

    // ======================================
    // Read path
    // ======================================

    // Select the addressed word, unmapped blocks give zero
    always_comb
    begin
        case (blk)
            CSR_BLK_GLOB:
            begin
                rd_word = eng_csr_glob.rd_data[idx];
            end
            CSR_BLK_ENG:
            begin
                rd_word = eng_csr.rd_data[idx];
            end
            default:
            begin
                rd_word = '0;
            end
        endcase
    end

    // Valid follows the strobe by one cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            readdatavalid <= 1'b0;
        end
        else
        begin
            readdatavalid <= rd_read;
        end
    end

    // Data captured with the strobe
    always_ff @(posedge clk)
    begin
        if (rd_read)
        begin
            readdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== engine_csr_if.sv ====
// ======================================
// Register block link between the
// manager and one register block
// ======================================

`timescale 1ns/100ps
`default_nettype none

`include "afu_macros.svh"

interface engine_csr_if
    import csr_pkg::*;
();

    // Write path, one-cycle strobe from the manager
    logic                   wr_en;
    csr_idx_t               wr_idx;
    logic [`AFU_DATA_W-1:0] wr_data;

    // Read words, always presented by the block
    logic [`AFU_DATA_W-1:0] rd_data [`AFU_NUM_CSRS];

    // Block is doing work
    logic                   status_active;

    modport manager
    (
        output wr_en,
        output wr_idx,
        output wr_data,
        input  rd_data,
        input  status_active
    );

    modport block
    (
        input  wr_en,
        input  wr_idx,
        input  wr_data,
        output rd_data,
        output status_active
    );

endinterface

`default_nettype wire

// ==== eng_pkg.sv ====
// ======================================
// Copy engine state and address types
// ======================================

`default_nettype none

package eng_pkg;

    // Host memory line address
    localparam int MEM_ADDR_W = 64;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // One read handshake then one write handshake per line
    typedef enum logic [2:0]
    {
        // Waiting for a start
        ENG_IDLE    = 3'd0,
        // Read request raised, waiting for ack
        ENG_RD_REQ  = 3'd1,
        // Read request dropped, waiting for ack low
        ENG_RD_REL  = 3'd2,
        // Write request raised, waiting for ack
        ENG_WR_REQ  = 3'd3,
        // Write request dropped, waiting for ack low
        ENG_WR_REL  = 3'd4,
        // Copy finished, done bit shown
        ENG_DONE    = 3'd5
    } eng_state_t;

endpackage

`default_nettype wire

// ==== csr_pkg.sv ====
// ======================================
// Register-space types, register numbers
// and block decode values
// ======================================

`default_nettype none

`include "afu_macros.svh"

package csr_pkg;

    // Register index inside one block
    localparam int CSR_IDX_W = $clog2(`AFU_NUM_CSRS);
    typedef logic [CSR_IDX_W-1:0] csr_idx_t;

    // Block number from the upper address bits
    typedef logic [`AFU_MMIO_ADDR_W-CSR_IDX_W-1:0] csr_blk_t;
    localparam csr_blk_t CSR_BLK_GLOB = 0;
    localparam csr_blk_t CSR_BLK_ENG  = 1;

    // Global block
    localparam csr_idx_t CSR_GLOB_ID_LO = 0;
    localparam csr_idx_t CSR_GLOB_ID_HI = 1;
    localparam csr_idx_t CSR_GLOB_INFO  = 2;

    // Engine block
    localparam csr_idx_t CSR_ENG_CTRL   = 0;
    localparam csr_idx_t CSR_ENG_SRC    = 1;
    localparam csr_idx_t CSR_ENG_DST    = 2;
    localparam csr_idx_t CSR_ENG_LEN    = 3;
    localparam csr_idx_t CSR_ENG_STATUS = 4;
    localparam csr_idx_t CSR_ENG_COUNT  = 5;
    localparam csr_idx_t CSR_ENG_SUM    = 6;

    // Bit positions in CTRL and STATUS
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // Info word: engines in [7:0], instance in [31:24], rest zero
    function automatic logic [`AFU_DATA_W-1:0] csr_info_word(
        input logic [7:0] inst,
        input logic [7:0] n_eng
    );
        return {32'd0, inst, 16'd0, n_eng};
    endfunction

endpackage

`default_nettype wire

// ==== afu_macros.svh ====
// ======================================
// Build-wide sizes and identity values
// for the accelerator function unit
// ======================================

`ifndef AFU_MACROS_SVH
`define AFU_MACROS_SVH

// Width of register and memory data words
`define AFU_DATA_W 64

// Register word address from the host
`define AFU_MMIO_ADDR_W 6

// Registers in each block (global and per engine)
`define AFU_NUM_CSRS 8

// Copy engines built into the unit
`define AFU_NUM_ENGINES 1

// Instance number shown in the info register
`define AFU_INSTANCE_ID 5

// 128-bit test identifier, low half at register 0
`define AFU_TEST_ID 128'h7e2a91d4_3bc0_4f65_9a1e_d08c55f2b317

`endif
